// ==== branch_exec.f ====
hdl/branch_pkg.sv
hdl/branch_cond.sv
hdl/branch_target.sv
hdl/branch_resolve.sv
hdl/branch_exec.sv
test/tb_clock_gen.sv
test/branch_exec_tb.sv

// ==== hdl/branch_cond.sv ====
module branch_cond
    import branch_pkg::*;
(
    input  alu_op_t aluop,
    input  word_t   reg1,
    input  word_t   reg2,

    output logic    is_branch,
    output logic    is_taken
);

    logic use_signed;
    logic reg1_eq_reg2;
    logic reg1_lt_signed;
    logic reg1_lt_unsigned;
    logic reg1_lt_reg2;

    // --------------------------------------------------
    // Operand compare
    // --------------------------------------------------

    assign use_signed = (aluop == ALU_BLT) || (aluop == ALU_BGE);

    assign reg1_eq_reg2     = (reg1 == reg2);
    assign reg1_lt_signed   = ($signed(reg1) < $signed(reg2));
    assign reg1_lt_unsigned = (reg1 < reg2);

    // One less-than result serves both signed and unsigned branches.
    assign reg1_lt_reg2 = use_signed ? reg1_lt_signed : reg1_lt_unsigned;

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------

    always_comb begin
        is_branch = 1'b1;
        is_taken  = 1'b0;
        case (aluop)
            ALU_BEQ: begin
                is_taken = reg1_eq_reg2;
            end
            ALU_BNE: begin
                is_taken = !reg1_eq_reg2;
            end
            ALU_BLT, ALU_BLTU: begin
                is_taken = reg1_lt_reg2;
            end
            ALU_BGE, ALU_BGEU: begin
                is_taken = !reg1_lt_reg2;
            end
            ALU_B, ALU_BL, ALU_JIRL: begin
                is_taken = 1'b1; // Jumps always redirect fetch.
            end
            default: begin
                is_branch = 1'b0;
                is_taken  = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/branch_exec.sv ====
module branch_exec
    import branch_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    input  word_t   pc,
    input  word_t   inst,
    input  alu_op_t aluop,
    input  word_t   reg1,
    input  word_t   reg2,

    input  logic    pred_taken,
    input  word_t   pred_addr,

    output logic    upd_valid,
    output word_t   upd_pc,
    output logic    upd_taken,
    output word_t   upd_addr,
    output logic    flush,
    output word_t   alu_res
);

    logic  is_branch;
    logic  is_taken;
    word_t target_addr;
    word_t link_res;

    // --------------------------------------------------
    // Direction and target blocks
    // --------------------------------------------------

    branch_cond i_branch_cond (
        .aluop     (aluop),
        .reg1      (reg1),
        .reg2      (reg2),
        .is_branch (is_branch),
        .is_taken  (is_taken)
    );

    branch_target i_branch_target (
        .pc          (pc),
        .inst        (inst),
        .reg1        (reg1),
        .aluop       (aluop),
        .target_addr (target_addr),
        .link_res    (link_res)
    );

    // Single register stage of the unit.
    branch_resolve i_branch_resolve (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .pc          (pc),
        .is_branch   (is_branch),
        .is_taken    (is_taken),
        .target_addr (target_addr),
        .link_res    (link_res),
        .pred_taken  (pred_taken),
        .pred_addr   (pred_addr),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .upd_addr    (upd_addr),
        .flush       (flush),
        .alu_res     (alu_res)
    );

endmodule

// ==== hdl/branch_pkg.sv ====
package branch_pkg;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    typedef logic [31:0] word_t;   // Machine word for pc, operands and addresses.
    typedef logic [7:0]  alu_op_t; // Decoded ALU opcode from the issue stage.

    // --------------------------------------------------
    // Branch opcodes
    // --------------------------------------------------

    // Any value not listed here is treated as a non-branch operation.
    localparam alu_op_t ALU_NOP  = 8'h00;
    localparam alu_op_t ALU_BEQ  = 8'h58;
    localparam alu_op_t ALU_BNE  = 8'h59;
    localparam alu_op_t ALU_BLT  = 8'h5a;
    localparam alu_op_t ALU_BGE  = 8'h5b;
    localparam alu_op_t ALU_BLTU = 8'h5c;
    localparam alu_op_t ALU_BGEU = 8'h5d;
    localparam alu_op_t ALU_B    = 8'h50;
    localparam alu_op_t ALU_BL   = 8'h51;
    localparam alu_op_t ALU_JIRL = 8'h4c;

    // Sequential fetch step, one instruction.
    localparam word_t INST_BYTES = 32'd4;

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------

    // The 16-bit offset sits in bits 25..10.
    localparam int OFFS16_HI = 25;
    localparam int OFFS16_LO = 10;

    // The 26-bit offset is split over two fields.
    // Its upper ten bits sit in bits 9..0 and its lower
    // sixteen bits reuse the 16-bit offset field.
    localparam int OFFS26_HI = 9;
    localparam int OFFS26_LO = 0;

    // Both offsets count instructions and are scaled
    // to bytes by a shift of two before use.

endpackage

// ==== hdl/branch_resolve.sv ====
module branch_resolve
    import branch_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  in_valid,
    input  word_t pc,

    input  logic  is_branch,
    input  logic  is_taken,
    input  word_t target_addr,
    input  word_t link_res,

    input  logic  pred_taken,
    input  word_t pred_addr,

    output logic  upd_valid,
    output word_t upd_pc,
    output logic  upd_taken,
    output word_t upd_addr,
    output logic  flush,
    output word_t alu_res
);

    word_t pc_fall;
    word_t act_addr;
    logic  act_taken;
    logic  act_flush;

    assign pc_fall = pc + INST_BYTES;

    // --------------------------------------------------
    // Outcome versus prediction
    // --------------------------------------------------

    always_comb begin
        act_taken = 1'b0;
        act_addr  = '0;
        act_flush = 1'b0;
        if (is_branch) begin
            act_taken = is_taken;
            if (is_taken && pred_taken) begin
                act_addr = target_addr;
                // Right direction but the predicted target may still be stale.
                act_flush = (pred_addr != target_addr);
            end else if (is_taken && !pred_taken) begin
                act_addr  = target_addr;
                act_flush = 1'b1;
            end else if (!is_taken && pred_taken) begin
                act_addr  = pc_fall; // Fetch resumes at the next instruction.
                act_flush = 1'b1;
            end else begin
                act_addr  = '0;
                act_flush = 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    // The data outputs keep their value between strobes.
    // Only the two pulses are dropped in idle cycles.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            upd_valid <= 1'b0;
            upd_pc    <= '0;
            upd_taken <= 1'b0;
            upd_addr  <= '0;
            flush     <= 1'b0;
            alu_res   <= '0;
        end else if (in_valid) begin
            upd_valid <= is_branch;
            upd_pc    <= is_branch ? pc : '0;
            upd_taken <= act_taken;
            upd_addr  <= act_addr;
            flush     <= act_flush;
            alu_res   <= link_res; // Zero for everything except BL and JIRL.
        end else begin
            upd_valid <= 1'b0;
            flush     <= 1'b0;
        end
    end

endmodule

// ==== hdl/branch_target.sv ====
module branch_target
    import branch_pkg::*;
(
    input  word_t   pc,
    input  word_t   inst,
    input  word_t   reg1,
    input  alu_op_t aluop,

    output word_t   target_addr,
    output word_t   link_res
);

    word_t offs16;
    word_t offs26;
    word_t pc_next;

    // --------------------------------------------------
    // Offset extraction
    // --------------------------------------------------

    // Sign extended and scaled from instructions to bytes.
    assign offs16 = {{14{inst[OFFS16_HI]}},
                     inst[OFFS16_HI:OFFS16_LO],
                     2'b00};

    assign offs26 = {{4{inst[OFFS26_HI]}},
                     inst[OFFS26_HI:OFFS26_LO],
                     inst[OFFS16_HI:OFFS16_LO],
                     2'b00};

    assign pc_next = pc + INST_BYTES; // Return address for calls.

    // --------------------------------------------------
    // Target and link per opcode
    // --------------------------------------------------

    always_comb begin
        target_addr = '0;
        link_res    = '0;
        case (aluop)
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                target_addr = pc + offs16;
            end
            ALU_B: begin
                target_addr = pc + offs26;
            end
            ALU_BL: begin
                target_addr = pc + offs26;
                link_res    = pc_next;
            end
            ALU_JIRL: begin
                // The base of a register indirect jump comes from reg1.
                target_addr = reg1 + offs16;
                link_res    = pc_next;
            end
            default: begin
                target_addr = '0;
                link_res    = '0;
            end
        endcase
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the branch unit testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module branch_exec_tb \
    -f branch_exec.f -o sim_branch_exec
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_branch_exec > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "The simulation model exited with status $run_status"
    exit 1
fi

grep -q "^Simulation passed$" sim.log
if [ $? -ne 0 ]; then
    echo "Pass message not found in sim.log"
    exit 1
fi

exit 0

// ==== test/branch_exec_tb.sv ====
module branch_exec_tb
    import branch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ENTRIES      = 24;
    localparam int TIMEOUT_CYCLES = 10 + 2 * N_ENTRIES + 20;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    word_t   pc;
    word_t   inst;
    alu_op_t aluop;
    word_t   reg1;
    word_t   reg2;
    logic    pred_taken;
    word_t   pred_addr;
    logic    upd_valid;
    word_t   upd_pc;
    logic    upd_taken;
    word_t   upd_addr;
    logic    flush;
    word_t   alu_res;

    // --------------------------------------------------
    // Stimulus table and expected values
    // --------------------------------------------------

    word_t   tbl_pc   [N_ENTRIES];
    word_t   tbl_inst [N_ENTRIES];
    alu_op_t tbl_op   [N_ENTRIES];
    word_t   tbl_reg1 [N_ENTRIES];
    word_t   tbl_reg2 [N_ENTRIES];
    logic    tbl_pt   [N_ENTRIES];
    word_t   tbl_pa   [N_ENTRIES];
    logic    tbl_gap  [N_ENTRIES]; // Idle cycle after the entry.

    logic    exp_valid [N_ENTRIES];
    word_t   exp_pc    [N_ENTRIES];
    logic    exp_taken [N_ENTRIES];
    word_t   exp_addr  [N_ENTRIES];
    logic    exp_flush [N_ENTRIES];
    word_t   exp_res   [N_ENTRIES];

    alu_op_t op_list [10] = '{ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU,
                              ALU_BGEU, ALU_B, ALU_BL, ALU_JIRL, ALU_NOP};

    int pend_q [$]; // Entries strobed in the previous cycle.
    int err_cnt      = 0;
    int fail_cnt     = 0;
    int entries_done = 0;
    int cycle_cnt    = 0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    branch_exec i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .pc         (pc),
        .inst       (inst),
        .aluop      (aluop),
        .reg1       (reg1),
        .reg2       (reg2),
        .pred_taken (pred_taken),
        .pred_addr  (pred_addr),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_addr   (upd_addr),
        .flush      (flush),
        .alu_res    (alu_res)
    );

    function automatic word_t encode_offs16(input logic [15:0] offs);
        return {6'b0, offs, 10'b0};
    endfunction

    // Low half goes to bits 25..10, high ten bits to bits 9..0.
    function automatic word_t encode_offs26(input logic [25:0] offs);
        return {6'b0, offs[15:0], offs[25:16]};
    endfunction

    task automatic set_entry(input int i, input word_t e_pc, input word_t e_inst,
                             input alu_op_t e_op, input word_t e_r1, input word_t e_r2,
                             input logic e_pt, input word_t e_pa, input logic e_gap);
        tbl_pc[i]   = e_pc;
        tbl_inst[i] = e_inst;
        tbl_op[i]   = e_op;
        tbl_reg1[i] = e_r1;
        tbl_reg2[i] = e_r2;
        tbl_pt[i]   = e_pt;
        tbl_pa[i]   = e_pa;
        tbl_gap[i]  = e_gap;
    endtask

    task automatic fill_random(input int first);
        word_t rnd;
        word_t r1;
        int    sel;
        for (int i = first; i < N_ENTRIES; i++) begin
            rnd = $urandom;
            sel = int'(rnd % 32'd10);
            r1  = $urandom;
            // Equal operands about half the time.
            set_entry(i, $urandom & 32'hFFFF_FFFC, $urandom, op_list[sel], r1,
                      rnd[5] ? r1 : $urandom, rnd[4], $urandom & 32'hFFFF_FFFC, rnd[7]);
        end
    endtask

    // Reference model of the branch rules.
    task automatic model_entry(input int i);
        word_t ins;
        word_t r1;
        word_t r2;
        word_t off16;
        word_t off26;
        word_t target;
        logic  branch;
        logic  taken;
        ins    = tbl_inst[i];
        r1     = tbl_reg1[i];
        r2     = tbl_reg2[i];
        off16  = {{16{ins[OFFS16_HI]}}, ins[OFFS16_HI:OFFS16_LO]} << 2;
        off26  = {{6{ins[OFFS26_HI]}}, ins[OFFS26_HI:OFFS26_LO],
                  ins[OFFS16_HI:OFFS16_LO]} << 2;
        branch = 1'b1;
        taken  = 1'b0;
        case (tbl_op[i])
            ALU_BEQ:                 taken = (r1 == r2);
            ALU_BNE:                 taken = (r1 != r2);
            ALU_BLT:                 taken = ($signed(r1) < $signed(r2));
            ALU_BGE:                 taken = ($signed(r1) >= $signed(r2));
            ALU_BLTU:                taken = (r1 < r2);
            ALU_BGEU:                taken = (r1 >= r2);
            ALU_B, ALU_BL, ALU_JIRL: taken = 1'b1;
            default:                 branch = 1'b0;
        endcase
        case (tbl_op[i])
            ALU_B, ALU_BL: target = tbl_pc[i] + off26;
            ALU_JIRL:      target = r1 + off16;
            default:       target = tbl_pc[i] + off16;
        endcase
        exp_valid[i] = branch;
        exp_pc[i]    = branch ? tbl_pc[i] : '0;
        exp_taken[i] = branch & taken;
        exp_addr[i]  = '0;
        exp_flush[i] = 1'b0;
        exp_res[i]   = '0;
        if (tbl_op[i] == ALU_BL || tbl_op[i] == ALU_JIRL) begin
            exp_res[i] = tbl_pc[i] + 32'd4;
        end
        if (branch && taken) begin
            exp_addr[i]  = target;
            exp_flush[i] = !tbl_pt[i] || (tbl_pa[i] != target);
        end else if (branch && tbl_pt[i]) begin
            exp_addr[i]  = tbl_pc[i] + 32'd4;
            exp_flush[i] = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_entry(input int i);
        int err_before;
        err_before = err_cnt;
        check_flag("upd_valid", upd_valid, exp_valid[i]);
        check_word("upd_pc", upd_pc, exp_pc[i]);
        check_flag("upd_taken", upd_taken, exp_taken[i]);
        check_word("upd_addr", upd_addr, exp_addr[i]);
        check_flag("flush", flush, exp_flush[i]);
        check_word("alu_res", alu_res, exp_res[i]);
        if (err_cnt == err_before) begin
            $display("Entry %0d op %h: ok", i, tbl_op[i]);
        end else begin
            $display("Entry %0d op %h: mismatch", i, tbl_op[i]);
            fail_cnt++;
        end
        entries_done++;
    endtask

    task automatic check_reset_state(input string phase);
        int err_before;
        err_before = err_cnt;
        check_flag("upd_valid", upd_valid, 1'b0);
        check_word("upd_pc", upd_pc, '0);
        check_flag("upd_taken", upd_taken, 1'b0);
        check_word("upd_addr", upd_addr, '0);
        check_flag("flush", flush, 1'b0);
        check_word("alu_res", alu_res, '0);
        $display("Reset check %s: %s", phase, (err_cnt == err_before) ? "ok" : "mismatch");
    endtask

    // Each falling edge checks the last cycle's result and then drives the next.
    task automatic next_cycle(input logic drive, input int i);
        @(negedge clk);
        if (pend_q.size() != 0) begin
            check_entry(pend_q.pop_front());
        end else begin
            check_flag("upd_valid (idle)", upd_valid, 1'b0);
            check_flag("flush (idle)", flush, 1'b0);
        end
        in_valid = drive; // Idle cycles keep the old operands on the bus.
        if (drive) begin
            pc         = tbl_pc[i];
            inst       = tbl_inst[i];
            aluop      = tbl_op[i];
            reg1       = tbl_reg1[i];
            reg2       = tbl_reg2[i];
            pred_taken = tbl_pt[i];
            pred_addr  = tbl_pa[i];
            pend_q.push_back(i);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        in_valid   = 1'b0;
        pc         = '0;
        inst       = '0;
        aluop      = ALU_NOP;
        reg1       = '0;
        reg2       = '0;
        pred_taken = 1'b0;
        pred_addr  = '0;
        void'($urandom(80));

        set_entry(0,  32'h0000_1000, encode_offs16(16'h0010), ALU_BEQ, 32'h0000_1234,
                  32'h0000_1234, 1'b1, 32'h0000_1040, 1'b0);
        set_entry(1,  32'h0000_1004, encode_offs16(16'h0020), ALU_BEQ, 32'd5, 32'd6,
                  1'b0, 32'h0, 1'b1);
        set_entry(2,  32'h0000_1008, encode_offs16(16'h0004), ALU_BNE, 32'hFFFF_FFFF, 32'd1,
                  1'b0, 32'h0, 1'b0);
        set_entry(3,  32'h0000_100C, encode_offs16(16'h0004), ALU_BNE, 32'd7, 32'd7,
                  1'b1, 32'h0000_101C, 1'b0);
        set_entry(4,  32'h0000_2000, encode_offs16(16'hFFF8), ALU_BLT, 32'hFFFF_FFF0, 32'd3,
                  1'b1, 32'h0000_2100, 1'b1);
        set_entry(5,  32'h0000_2004, encode_offs16(16'hFFF8), ALU_BLTU, 32'hFFFF_FFF0, 32'd3,
                  1'b0, 32'h0, 1'b0);
        set_entry(6,  32'h0000_2008, encode_offs16(16'h0040), ALU_BGE, 32'd3, 32'hFFFF_FFF0,
                  1'b1, 32'h0000_2108, 1'b0);
        set_entry(7,  32'h0000_200C, encode_offs16(16'h0040), ALU_BGEU, 32'd3, 32'hFFFF_FFF0,
                  1'b1, 32'h0000_210C, 1'b0);
        set_entry(8,  32'h0000_3000, encode_offs16(16'h0001), ALU_BLT, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 1'b0, 32'h0, 1'b0);
        set_entry(9,  32'h0000_3004, encode_offs16(16'h0001), ALU_BGE, 32'h8000_0000,
                  32'h8000_0000, 1'b0, 32'h0, 1'b1);
        set_entry(10, 32'h0000_3008, encode_offs16(16'h0002), ALU_BLTU, 32'd1, 32'h8000_0000,
                  1'b1, 32'h0000_3010, 1'b0);
        set_entry(11, 32'h0000_300C, encode_offs16(16'h0002), ALU_BGEU, 32'h0000_ABCD,
                  32'h0000_ABCD, 1'b1, 32'h0000_3014, 1'b0);
        set_entry(12, 32'h0000_4000, encode_offs26(26'h000_0100), ALU_B, 32'h0, 32'h0,
                  1'b1, 32'h0000_4400, 1'b0);
        set_entry(13, 32'h0000_4004, encode_offs26(26'h3FF_FFF0), ALU_BL, 32'h0, 32'h0,
                  1'b0, 32'h0, 1'b1);
        set_entry(14, 32'h0000_5000, encode_offs16(16'h0008), ALU_JIRL, 32'h2000_0000, 32'h0,
                  1'b1, 32'h2000_0000, 1'b0);
        set_entry(15, 32'h0000_5004, 32'h0, ALU_NOP, 32'd1, 32'd2, 1'b0, 32'h0, 1'b1);
        set_entry(16, 32'h0000_5008, encode_offs16(16'h0010), 8'h11, 32'd3, 32'd3,
                  1'b1, 32'h0000_5048, 1'b0);
        set_entry(17, 32'h0000_6000, encode_offs16(16'h0003), ALU_BLTU, 32'h8000_0000,
                  32'h8000_0000, 1'b1, 32'h0000_600C, 1'b0);
        fill_random(18);
        for (int i = 0; i < N_ENTRIES; i++) begin
            model_entry(i);
        end

        repeat (2) @(negedge clk);
        check_reset_state("during reset");
        wait (rst_n === 1'b1);
        check_reset_state("after reset");

        for (int i = 0; i < N_ENTRIES; i++) begin
            next_cycle(1'b1, i);
            if (tbl_gap[i]) begin
                next_cycle(1'b0, 0);
            end
        end
        next_cycle(1'b0, 0); // Collects the last result.
        next_cycle(1'b0, 0);

        $display("Entries checked: %0d of %0d, failed: %0d, errors: %0d",
                 entries_done, N_ENTRIES, fail_cnt, err_cnt);
        if (err_cnt == 0 && entries_done == N_ENTRIES) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hard stop if the sequence above stalls.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    // Reset is held for ten rising edges and released on a falling edge.
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
